// File: source/mem_arb_pkg.sv
// shared widths, limits, enums and bus structs of the memory arbiter, imported by each module
package mem_arb_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and limits
    //////////////////////////////////////////////////////////////////////

    // processor word
    localparam int XLEN          = 32;
    // memory bus data path
    localparam int MEM_DATA_BITS = 64;
    // response and reply tags
    localparam int TAG_BITS      = 4;
    // longest wait allowed for one load
    localparam int WAIT_LIMIT    = 15;
    localparam int WAIT_BITS     = 4;

    //////////////////////////////////////////////////////////////////////
    // scalar types
    //////////////////////////////////////////////////////////////////////

    // zero tag means no tag
    typedef logic [TAG_BITS-1:0] mem_tag_t;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_LOAD  = 2'd1,
        BUS_STORE = 2'd2
    } bus_command_t;

    typedef enum logic [1:0] {
        BYTE   = 2'd0,
        HALF   = 2'd1,
        WORD   = 2'd2,
        DOUBLE = 2'd3
    } mem_size_t;

    // who holds the bus while a load is outstanding
    typedef enum logic [1:0] {
        OWNER_NONE = 2'd0,
        OWNER_DATA = 2'd1,
        OWNER_INST = 2'd2
    } bus_owner_t;

    //////////////////////////////////////////////////////////////////////
    // request and reply bundles
    //////////////////////////////////////////////////////////////////////

    // fetch side, always a full double on the bus
    typedef struct packed {
        bus_command_t    command;
        logic [XLEN-1:0] addr;
    } inst_req_t;

    // data side, word of store data
    typedef struct packed {
        bus_command_t    command;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
        mem_size_t       size;
    } data_req_t;

    typedef struct packed {
        bus_command_t             command;
        logic [XLEN-1:0]          addr;
        logic [MEM_DATA_BITS-1:0] data;
        mem_size_t                size;
    } mem_req_t;

    // response is nonzero in the accept cycle, tag marks returning data
    typedef struct packed {
        mem_tag_t                 response;
        mem_tag_t                 tag;
        logic [MEM_DATA_BITS-1:0] data;
    } mem_reply_t;

    typedef struct packed {
        logic                     valid;
        logic [MEM_DATA_BITS-1:0] data;
    } src_reply_t;

endpackage

// File: source/bus_owner_fsm.sv
// bus ownership FSM, picks the data or fetch request for the memory bus and strobes accepts
module bus_owner_fsm import mem_arb_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  inst_req_t  inst_req,
    input  data_req_t  data_req,
    input  mem_tag_t   response,
    input  logic       reply_done,
    input  logic       wait_expired,
    output mem_req_t   mem_req,
    output logic       inst_accept,
    output logic       data_accept,
    output logic       load_accepted,
    output bus_owner_t owner,
    output logic       fetch_stall
);

    bus_owner_t owner_next;
    logic       bus_idle;
    logic       data_present;
    logic       inst_present;
    logic       accepted;
    logic       data_load;
    logic       inst_load;

    //////////////////////////////////////////////////////////////////////
    // request selection
    //////////////////////////////////////////////////////////////////////

    assign bus_idle     = (owner == OWNER_NONE);
    assign data_present = (data_req.command != BUS_NONE);
    assign inst_present = (inst_req.command != BUS_NONE);

    // data side always wins
    always_comb begin
        if (data_present) begin
            mem_req.command = data_req.command;
            mem_req.addr    = data_req.addr;
            // store word goes out in the low half
            mem_req.data    = {{(MEM_DATA_BITS-XLEN){1'b0}}, data_req.data};
            mem_req.size    = data_req.size;
        end else begin
            mem_req.command = inst_req.command;
            mem_req.addr    = inst_req.addr;
            mem_req.data    = '0;
            // fetch reads a full double
            mem_req.size    = DOUBLE;
        end
        // nothing new while a load is in flight
        if (!bus_idle) begin
            mem_req.command = BUS_NONE;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // accept strobes
    //////////////////////////////////////////////////////////////////////

    // nonzero response means memory took this cycle's request
    assign accepted    = bus_idle && (response != '0);
    assign data_accept = accepted && data_present;
    assign inst_accept = accepted && !data_present && inst_present;

    // stores finish here, loads hold the bus
    assign data_load     = data_accept && (data_req.command == BUS_LOAD);
    assign inst_load     = inst_accept && (inst_req.command == BUS_LOAD);
    assign load_accepted = data_load || inst_load;

    //////////////////////////////////////////////////////////////////////
    // owner state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        owner_next = owner;
        case (owner)
            OWNER_NONE: begin
                if (data_load) begin
                    owner_next = OWNER_DATA;
                end else if (inst_load) begin
                    owner_next = OWNER_INST;
                end
            end
            OWNER_DATA,
            OWNER_INST: begin
                // tag match or give up on the load
                if (reply_done || wait_expired) begin
                    owner_next = OWNER_NONE;
                end
            end
            default: begin
                owner_next = OWNER_NONE;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            owner <= OWNER_NONE;
        end else begin
            owner <= owner_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // fetch stall
    //////////////////////////////////////////////////////////////////////

    // data load in flight or data command waiting
    assign fetch_stall = (owner == OWNER_DATA) || data_present;

endmodule

// File: source/bus_wait_timer.sv
// wait counter for an outstanding load, flags expiry and keeps a sticky bus timeout
module bus_wait_timer import mem_arb_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  bus_owner_t owner,
    output logic       wait_expired,
    output logic       bus_timeout
);

    logic [WAIT_BITS-1:0] wait_count;
    logic                 waiting;

    // any owner means a load is outstanding
    assign waiting = (owner != OWNER_NONE);

    // limit reached without a matching reply
    assign wait_expired = waiting && (wait_count == WAIT_BITS'(WAIT_LIMIT));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wait_count  <= '0;
            bus_timeout <= 1'b0;
        end else begin
            // count only while owned
            if (!waiting) begin
                wait_count <= '0;
            end else if (!wait_expired) begin
                wait_count <= wait_count + 1'b1;
            end
            // stays set until reset
            if (wait_expired) begin
                bus_timeout <= 1'b1;
            end
        end
    end

endmodule

// File: source/bus_reply_router.sv
// holds the expected load tag, matches memory replies and returns data to the owning side
module bus_reply_router import mem_arb_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  mem_tag_t   response,
    input  logic       load_accepted,
    input  bus_owner_t owner,
    input  mem_reply_t mem_reply,
    output logic       reply_done,
    output src_reply_t inst_reply,
    output src_reply_t data_reply
);

    mem_tag_t                 expected_tag;
    logic [MEM_DATA_BITS-1:0] reply_data_q;
    logic                     inst_valid_q;
    logic                     data_valid_q;
    logic                     tag_match;

    //////////////////////////////////////////////////////////////////////
    // tag tracking
    //////////////////////////////////////////////////////////////////////

    // memory echoes the response tag on the reply
    always_ff @(posedge clock) begin
        if (load_accepted) begin
            expected_tag <= response;
        end
    end

    // zero tag carries no data
    assign tag_match  = (mem_reply.tag != '0) && (mem_reply.tag == expected_tag);
    // only meaningful while someone owns the bus
    assign reply_done = (owner != OWNER_NONE) && tag_match;

    //////////////////////////////////////////////////////////////////////
    // reply register
    //////////////////////////////////////////////////////////////////////

    // one data register shared by both sides
    always_ff @(posedge clock) begin
        if (reply_done) begin
            reply_data_q <= mem_reply.data;
        end
    end

    // single cycle valid to the owner only
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            inst_valid_q <= 1'b0;
            data_valid_q <= 1'b0;
        end else begin
            inst_valid_q <= reply_done && (owner == OWNER_INST);
            data_valid_q <= reply_done && (owner == OWNER_DATA);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    assign inst_reply.valid = inst_valid_q;
    assign inst_reply.data  = reply_data_q;

    assign data_reply.valid = data_valid_q;
    assign data_reply.data  = reply_data_q;

endmodule

// File: source/mem_arbiter.sv
// top level of the shared memory bus arbiter between the fetch side and the data side
module mem_arbiter import mem_arb_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    // requesters
    input  inst_req_t  inst_req,
    input  data_req_t  data_req,
    // memory side
    input  mem_reply_t mem_reply,
    output mem_req_t   mem_req,
    // accept strobes back to the requesters
    output logic       inst_accept,
    output logic       data_accept,
    // load data back to the requesters
    output src_reply_t inst_reply,
    output src_reply_t data_reply,
    // status
    output logic       fetch_stall,
    output logic       bus_timeout
);

    bus_owner_t owner;
    logic       load_accepted;
    logic       reply_done;
    logic       wait_expired;

    //////////////////////////////////////////////////////////////////////
    // ownership and request mux
    //////////////////////////////////////////////////////////////////////

    bus_owner_fsm u_owner_fsm (
        .clock         (clock),
        .reset         (reset),
        .inst_req      (inst_req),
        .data_req      (data_req),
        .response      (mem_reply.response),
        .reply_done    (reply_done),
        .wait_expired  (wait_expired),
        .mem_req       (mem_req),
        .inst_accept   (inst_accept),
        .data_accept   (data_accept),
        .load_accepted (load_accepted),
        .owner         (owner),
        .fetch_stall   (fetch_stall)
    );

    //////////////////////////////////////////////////////////////////////
    // load wait limit
    //////////////////////////////////////////////////////////////////////

    bus_wait_timer u_wait_timer (
        .clock        (clock),
        .reset        (reset),
        .owner        (owner),
        .wait_expired (wait_expired),
        .bus_timeout  (bus_timeout)
    );

    //////////////////////////////////////////////////////////////////////
    // reply matching and return
    //////////////////////////////////////////////////////////////////////

    bus_reply_router u_reply_router (
        .clock         (clock),
        .reset         (reset),
        .response      (mem_reply.response),
        .load_accepted (load_accepted),
        .owner         (owner),
        .mem_reply     (mem_reply),
        .reply_done    (reply_done),
        .inst_reply    (inst_reply),
        .data_reply    (data_reply)
    );

endmodule

// File: tb/mem_arbiter_assert.sv
// concurrent checks on the bus owner FSM outputs, bound into every bus_owner_fsm instance
module mem_arbiter_assert import mem_arb_pkg::*; (
    input logic       clock,
    input logic       reset,
    input bus_owner_t owner,
    input mem_req_t   mem_req,
    input mem_tag_t   response,
    input logic       inst_accept,
    input logic       data_accept
);
    timeunit 1ns;
    timeprecision 100ps;

    // read back by the testbench every cycle
    int assert_failures = 0;

    // at most one side taken per cycle
    one_accept: assert property (@(posedge clock) disable iff (reset)
        !(inst_accept && data_accept))
        else begin
            assert_failures++;
            $error("inst_accept and data_accept high in the same cycle");
        end

    // bus stays quiet while a load is outstanding
    quiet_when_owned: assert property (@(posedge clock) disable iff (reset)
        (owner != OWNER_NONE) |-> (mem_req.command == BUS_NONE))
        else begin
            assert_failures++;
            $error("bus command driven while the bus is owned");
        end

    // accept only when memory answered with a tag
    accept_has_response: assert property (@(posedge clock) disable iff (reset)
        (inst_accept || data_accept) |-> (response != '0))
        else begin
            assert_failures++;
            $error("accept strobe without a memory response");
        end

endmodule

bind bus_owner_fsm mem_arbiter_assert u_fsm_assert (
    .clock       (clock),
    .reset       (reset),
    .owner       (owner),
    .mem_req     (mem_req),
    .response    (response),
    .inst_accept (inst_accept),
    .data_accept (data_accept)
);

// File: tb/mem_arbiter_tb.sv
// testbench of the memory arbiter, random requesters against a memory model and scoreboard
module mem_arbiter_tb import mem_arb_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RANDOM_CYCLES = 3000;
    localparam int WAIT_CYCLES   = 200;

    logic       clock;
    logic       reset;
    inst_req_t  inst_req;
    data_req_t  data_req;
    mem_reply_t mem_reply;
    mem_req_t   mem_req;
    logic       inst_accept;
    logic       data_accept;
    src_reply_t inst_reply;
    src_reply_t data_reply;
    logic       fetch_stall;
    logic       bus_timeout;

    // memory contents and pending reply
    logic [MEM_DATA_BITS-1:0] mem_array [0:255];
    mem_tag_t                 next_tag;
    logic                     reply_pending;
    int                       reply_countdown;
    logic [7:0]               reply_addr;
    logic                     withhold_next;
    // scoreboard
    bus_owner_t               model_owner;
    mem_tag_t                 model_tag;
    int                       model_wait;
    logic                     model_timeout;
    logic                     exp_inst_valid;
    logic                     exp_data_valid;
    logic [MEM_DATA_BITS-1:0] exp_reply_data;
    logic                     data_taken;
    logic                     inst_taken;
    int                       priority_count;
    int                       load_count;
    int                       store_count;
    int                       accepts_after_timeout;
    int                       cycles;

    mem_arbiter UUT (
        .clock       (clock),
        .reset       (reset),
        .inst_req    (inst_req),
        .data_req    (data_req),
        .mem_reply   (mem_reply),
        .mem_req     (mem_req),
        .inst_accept (inst_accept),
        .data_accept (data_accept),
        .inst_reply  (inst_reply),
        .data_reply  (data_reply),
        .fetch_stall (fetch_stall),
        .bus_timeout (bus_timeout)
    );

    always #20 clock = ~clock;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_wait(input string what);
        $display("timed out waiting for %s", what);
        $display("TEST FAILED");
        $fatal(1, "wait limit reached");
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus and memory model, driven just after the rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic drive_inputs();
        if (data_taken) begin
            data_req   = '0;
            data_taken = 1'b0;
        end
        if (inst_taken) begin
            inst_req   = '0;
            inst_taken = 1'b0;
        end
        // new requests only once the old one was taken
        if (data_req.command == BUS_NONE && $urandom_range(0, 1) == 1) begin
            data_req.command = ($urandom_range(0, 1) == 1) ? BUS_STORE : BUS_LOAD;
            data_req.addr    = $urandom_range(0, 63);
            data_req.data    = $urandom;
            data_req.size    = mem_size_t'($urandom_range(0, 3));
        end
        if (inst_req.command == BUS_NONE && $urandom_range(0, 1) == 1) begin
            inst_req.command = BUS_LOAD;
            inst_req.addr    = $urandom_range(0, 63);
        end
        mem_reply = '0;
        // accept half the time when something is on the bus
        if (model_owner == OWNER_NONE && (data_req.command != BUS_NONE ||
                inst_req.command != BUS_NONE) && $urandom_range(0, 1) == 1) begin
            mem_reply.response = next_tag;
        end
        if (reply_pending && reply_countdown == 0) begin
            mem_reply.tag  = model_tag;
            mem_reply.data = mem_array[reply_addr];
        end
    endtask

    task automatic start_load(input bus_owner_t side, input logic [7:0] addr);
        model_owner     = side;
        model_tag       = mem_reply.response;
        model_wait      = 0;
        reply_addr      = addr;
        reply_countdown = $urandom_range(0, 9);
        // one reply may be dropped on purpose
        reply_pending   = !withhold_next;
        withhold_next   = 1'b0;
        load_count++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // scoreboard, sampled at the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic check_cycle();
        logic         data_on;
        logic         inst_on;
        logic         idle;
        logic         accepted;
        bus_command_t exp_command;
        data_on     = (data_req.command != BUS_NONE);
        inst_on     = (inst_req.command != BUS_NONE);
        idle        = (model_owner == OWNER_NONE);
        accepted    = idle && (mem_reply.response != '0);
        exp_command = !idle ? BUS_NONE : (data_on ? data_req.command : inst_req.command);
        check_value("bus command", exp_command, mem_req.command);
        if (idle && data_on) begin
            check_value("data address", data_req.addr, mem_req.addr);
            // upper half of the bus must be zero
            check_value("bus data", {32'h0, data_req.data}, mem_req.data);
            check_value("data size", data_req.size, mem_req.size);
        end else if (idle && inst_on) begin
            check_value("fetch address", inst_req.addr, mem_req.addr);
            check_value("fetch size", DOUBLE, mem_req.size);
        end
        check_value("data accept", accepted && data_on, data_accept);
        check_value("inst accept", accepted && !data_on && inst_on, inst_accept);
        check_value("fetch stall", (model_owner == OWNER_DATA) || data_on, fetch_stall);
        check_value("bus timeout", model_timeout, bus_timeout);
        check_value("data reply valid", exp_data_valid, data_reply.valid);
        check_value("inst reply valid", exp_inst_valid, inst_reply.valid);
        if (exp_data_valid) begin
            check_value("data reply data", exp_reply_data, data_reply.data);
        end
        if (exp_inst_valid) begin
            check_value("inst reply data", exp_reply_data, inst_reply.data);
        end
        check_value("assertion failures", 0, UUT.u_owner_fsm.u_fsm_assert.assert_failures);
        exp_data_valid = 1'b0;
        exp_inst_valid = 1'b0;
        if (!idle) begin
            // matching tag ends the load, reply one cycle later
            if (mem_reply.tag != '0 && mem_reply.tag == model_tag) begin
                exp_data_valid = (model_owner == OWNER_DATA);
                exp_inst_valid = (model_owner == OWNER_INST);
                exp_reply_data = mem_array[reply_addr];
                model_owner    = OWNER_NONE;
                reply_pending  = 1'b0;
            end else if (model_wait == WAIT_LIMIT) begin
                model_timeout = 1'b1;
                model_owner   = OWNER_NONE;
                reply_pending = 1'b0;
            end else begin
                model_wait++;
                if (reply_pending && reply_countdown > 0) begin
                    reply_countdown--;
                end
            end
        end else if (accepted) begin
            next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            if (model_timeout) begin
                accepts_after_timeout++;
            end
            if (data_on) begin
                data_taken = 1'b1;
                if (inst_on) begin
                    priority_count++;
                end
                if (data_req.command == BUS_STORE) begin
                    mem_array[data_req.addr[7:0]] = {32'h0, data_req.data};
                    store_count++;
                end else begin
                    start_load(OWNER_DATA, data_req.addr[7:0]);
                end
            end else begin
                inst_taken = 1'b1;
                start_load(OWNER_INST, inst_req.addr[7:0]);
            end
        end
    endtask

    task automatic run_cycle();
        @(posedge clock);
        #2;
        drive_inputs();
        @(negedge clock);
        check_cycle();
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h224a));
        clock     = 1'b0;
        reset     = 1'b1;
        inst_req  = '0;
        data_req  = '0;
        mem_reply = '0;
        next_tag       = 4'd1;
        reply_pending  = 1'b0;
        withhold_next  = 1'b0;
        model_owner    = OWNER_NONE;
        model_tag      = '0;
        model_wait     = 0;
        model_timeout  = 1'b0;
        exp_inst_valid = 1'b0;
        exp_data_valid = 1'b0;
        data_taken     = 1'b0;
        inst_taken     = 1'b0;
        priority_count = 0;
        load_count     = 0;
        store_count    = 0;
        accepts_after_timeout = 0;
        for (int i = 0; i < 256; i++) begin
            mem_array[i] = {8'(i), 24'h5a0f3c, ~8'(i), 24'hc3a50f};
        end
        repeat (8) @(posedge clock);
        #2;
        reset = 1'b0;
        @(negedge clock);
        check_value("reset data accept", 0, data_accept);
        check_value("reset inst accept", 0, inst_accept);
        check_value("reset data reply", 0, data_reply.valid);
        check_value("reset inst reply", 0, inst_reply.valid);
        check_value("reset bus timeout", 0, bus_timeout);
        repeat (RANDOM_CYCLES) run_cycle();
        // drop the next load reply and wait for the timer
        withhold_next = 1'b1;
        cycles = 0;
        while (!model_timeout && cycles < WAIT_CYCLES) begin
            run_cycle();
            cycles++;
        end
        if (!model_timeout) begin
            fail_wait("the bus timeout after a withheld reply");
        end
        cycles = 0;
        while (accepts_after_timeout == 0 && cycles < WAIT_CYCLES) begin
            run_cycle();
            cycles++;
        end
        if (accepts_after_timeout == 0) begin
            fail_wait("a request accepted after the bus timeout");
        end
        check_value("priority cases seen", 1, priority_count > 0);
        check_value("loads seen", 1, load_count > 0);
        check_value("stores seen", 1, store_count > 0);
        if (UUT.u_owner_fsm.u_fsm_assert.assert_failures != 0) begin
            $display("assertion failures during the run");
            $display("TEST FAILED");
            $fatal(1, "assertion failure");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: list.f
source/mem_arb_pkg.sv
source/bus_owner_fsm.sv
source/bus_wait_timer.sv
source/bus_reply_router.sv
source/mem_arbiter.sv
tb/mem_arbiter_assert.sv
tb/mem_arbiter_tb.sv

// File: Bender.yml
package:
  name: mem_arbiter

sources:
  # synthesizable arbiter, package first
  - target: rtl
    files:
      - source/mem_arb_pkg.sv
      - source/bus_owner_fsm.sv
      - source/bus_wait_timer.sv
      - source/bus_reply_router.sv
      - source/mem_arbiter.sv

  # simulation only, top module mem_arbiter_tb
  - target: test
    files:
      - tb/mem_arbiter_assert.sv
      - tb/mem_arbiter_tb.sv
